// File: ctrl_state_pkg.sv
////////////////////////////////////////////////////////////////////////////
// controller state package
// state encoding of the main control FSM and the select codes it drives
// towards the fetch stage (pc select, exception target select)
////////////////////////////////////////////////////////////////////////////

package ctrl_state_pkg;

  // main FSM states
  // one register of 4 bits, room left for later states
  typedef enum logic [3:0] {
    RESET,
    BOOT_SET,
    WAIT_SLEEP,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH,
    IRQ_TAKEN
  } ctrl_state_e;

  // pc mux select seen by the prefetcher
  // codes 1, 3, 6 and 7 are unused by this controller
  typedef enum logic [2:0] {
    PC_BOOT      = 3'd0,
    PC_JUMP      = 3'd2,
    PC_EXCEPTION = 3'd4,
    PC_ERET      = 3'd5
  } pc_sel_e;

  // exception vector select, only valid with PC_EXCEPTION
  typedef enum logic [1:0] {
    EXC_PC_ILLINSN = 2'd0,
    EXC_PC_ECALL   = 2'd1,
    EXC_PC_IRQ     = 2'd3
  } exc_pc_sel_e;

endpackage

// File: trap_cause_pkg.sv
////////////////////////////////////////////////////////////////////////////
// trap cause package
// cause codes, the trap kinds seen by the classifier and the 6-bit cause
// word with its exception and interrupt views
////////////////////////////////////////////////////////////////////////////

package trap_cause_pkg;

  // cause word as written to mcause, and the interrupt id inside it
  localparam int CAUSE_W  = 6;
  localparam int IRQ_ID_W = 5;

  // synchronous exception codes
  localparam logic [CAUSE_W-2:0] EXC_ILLEGAL    = 5'd2;
  localparam logic [CAUSE_W-2:0] EXC_BREAKPOINT = 5'd3;
  localparam logic [CAUSE_W-2:0] EXC_ECALL_M    = 5'd11;

  // one cause word, decoded two ways
  // exception view has the top bit at zero
  // interrupt view has the top bit as the interrupt flag
  typedef union packed {
    struct packed {
      logic                 zero;
      logic [CAUSE_W-2:0]   code;
    } exc;
    struct packed {
      logic                 is_irq;
      logic [IRQ_ID_W-1:0]  id;
    } irq;
  } cause_u;

  // classified flush reason, TRAP_QUIET is a csr status write or pipe flush
  typedef enum logic [2:0] {
    TRAP_NONE,
    TRAP_ECALL,
    TRAP_ILLEGAL,
    TRAP_MRET,
    TRAP_EBREAK,
    TRAP_QUIET
  } trap_kind_e;

endpackage

// File: trap_if.sv
////////////////////////////////////////////////////////////////////////////
// trap record interface
// carries the classified trap from the classifier to the control FSM
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

interface trap_if;
  import ctrl_state_pkg::*;
  import trap_cause_pkg::*;

  // all fields are combinational, valid with the decoder flags
  trap_kind_e   kind;
  logic         flush_req;
  logic         irq_take;
  pc_sel_e      pc_sel;
  exc_pc_sel_e  exc_pc_sel;
  cause_u       exc_cause;
  cause_u       csr_cause;

  // classifier side
  modport classify (
    output kind, flush_req, irq_take, pc_sel, exc_pc_sel, exc_cause, csr_cause
  );

  // FSM side
  modport fsm (
    input  kind, flush_req, irq_take, pc_sel, exc_pc_sel, exc_cause, csr_cause
  );

endinterface

// File: trap_classify.sv
////////////////////////////////////////////////////////////////////////////
// trap classifier
// fixed priority over the decoder trap flags, cause word encoding and
// pc / exception target select, plus interrupt request gating
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module trap_classify (
  input  logic                                illegal_insn_i,
  input  logic                                ecall_insn_i,
  input  logic                                mret_insn_i,
  input  logic                                ebrk_insn_i,
  input  logic                                csr_status_i,
  input  logic                                pipe_flush_i,
  input  logic                                irq_req_i,
  input  logic                                m_ie_i,
  input  logic [trap_cause_pkg::IRQ_ID_W-1:0] irq_id_i,
  trap_if.classify                            trap
);
  import ctrl_state_pkg::*;
  import trap_cause_pkg::*;

  trap_kind_e  kind;
  pc_sel_e     pc_sel;
  exc_pc_sel_e exc_pc_sel;
  cause_u      exc_word;
  cause_u      csr_word;

  // synchronous exception word, built through the exception view
  function automatic cause_u exc_code(input logic [CAUSE_W-2:0] code);
    cause_u word;
    word.exc.zero = 1'b0;
    word.exc.code = code;
    return word;
  endfunction

  // priority: ecall, illegal, mret, ebreak, then the quiet flushes
  always_comb begin
    if (ecall_insn_i)
      kind = TRAP_ECALL;
    else if (illegal_insn_i)
      kind = TRAP_ILLEGAL;
    else if (mret_insn_i)
      kind = TRAP_MRET;
    else if (ebrk_insn_i)
      kind = TRAP_EBREAK;
    else if (csr_status_i || pipe_flush_i)
      kind = TRAP_QUIET;
    else
      kind = TRAP_NONE;
  end

  // targets and cause words per kind
  always_comb begin
    pc_sel     = PC_BOOT;
    exc_pc_sel = EXC_PC_IRQ;
    exc_word   = '0;
    csr_word   = '0;
    case (kind)
      TRAP_ECALL: begin
        pc_sel     = PC_EXCEPTION;
        exc_pc_sel = EXC_PC_ECALL;
        exc_word   = exc_code(EXC_ECALL_M);
        csr_word   = exc_code(EXC_ECALL_M);
      end
      TRAP_ILLEGAL: begin
        pc_sel     = PC_EXCEPTION;
        exc_pc_sel = EXC_PC_ILLINSN;
        exc_word   = exc_code(EXC_ILLEGAL);
        csr_word   = exc_code(EXC_ILLEGAL);
      end
      TRAP_MRET: begin
        pc_sel = PC_ERET;
      end
      // breakpoint only reports a cause, no redirect
      TRAP_EBREAK: begin
        exc_word = exc_code(EXC_BREAKPOINT);
      end
      TRAP_NONE: begin
        // interrupt view, flag clear towards the vector, set towards mcause
        pc_sel              = PC_EXCEPTION;
        exc_word.irq.is_irq = 1'b0;
        exc_word.irq.id     = irq_id_i;
        csr_word.irq.is_irq = 1'b1;
        csr_word.irq.id     = irq_id_i;
      end
      default: begin
        // quiet flush, nothing beyond the flush itself
        pc_sel = PC_BOOT;
      end
    endcase
  end

  assign trap.kind       = kind;
  assign trap.flush_req  = (kind != TRAP_NONE);
  // interrupt only counts when globally enabled
  assign trap.irq_take   = irq_req_i & m_ie_i;
  assign trap.pc_sel     = pc_sel;
  assign trap.exc_pc_sel = exc_pc_sel;
  assign trap.exc_cause  = exc_word;
  assign trap.csr_cause  = csr_word;

endmodule

// File: ctrl_fsm.sv
////////////////////////////////////////////////////////////////////////////
// main control FSM
// boot, fetch, decode, flush, sleep and interrupt entry sequencing,
// driving pc set, halt and csr save / restore strobes per state
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module ctrl_fsm (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          fetch_enable_i,
  input  logic                          instr_valid_i,
  input  logic                          id_ready_i,
  input  logic                          branch_set_i,
  input  logic                          jump_set_i,
  input  logic                          branch_in_id_i,
  input  logic                          instr_multicycle_i,
  trap_if.fsm                           trap,
  output logic                          ctrl_busy_o,
  output logic                          first_fetch_o,
  output logic                          is_decoding_o,
  output logic                          instr_req_o,
  output logic                          pc_set_o,
  output ctrl_state_pkg::pc_sel_e       pc_mux_o,
  output ctrl_state_pkg::exc_pc_sel_e   exc_pc_mux_o,
  output trap_cause_pkg::cause_u        exc_cause_o,
  output trap_cause_pkg::cause_u        csr_cause_o,
  output logic                          irq_ack_o,
  output logic                          exc_ack_o,
  output logic                          csr_save_if_o,
  output logic                          csr_save_id_o,
  output logic                          csr_save_cause_o,
  output logic                          csr_restore_mret_o,
  output logic                          halt_if_o,
  output logic                          halt_id_o
);
  import ctrl_state_pkg::*;
  import trap_cause_pkg::*;

  ctrl_state_e ctrl_fsm_cs;
  ctrl_state_e ctrl_fsm_ns;
  logic        irq_allowed;

  // an interrupt may not split a multicycle op or a branch under decision
  assign irq_allowed = trap.irq_take & ~instr_multicycle_i & ~branch_in_id_i;

  //////////////////////////////////////////////////////////////////////////
  // next state and output strobes
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    ctrl_fsm_ns        = ctrl_fsm_cs;
    ctrl_busy_o        = 1'b1;
    first_fetch_o      = 1'b0;
    is_decoding_o      = 1'b0;
    instr_req_o        = 1'b1;
    pc_set_o           = 1'b0;
    pc_mux_o           = PC_BOOT;
    exc_pc_mux_o       = EXC_PC_IRQ;
    exc_cause_o        = '0;
    csr_cause_o        = '0;
    irq_ack_o          = 1'b0;
    exc_ack_o          = 1'b0;
    csr_save_if_o      = 1'b0;
    csr_save_id_o      = 1'b0;
    csr_save_cause_o   = 1'b0;
    csr_restore_mret_o = 1'b0;
    halt_if_o          = 1'b0;
    halt_id_o          = 1'b0;

    case (ctrl_fsm_cs)
      // idle until the core is enabled
      RESET: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i)
          ctrl_fsm_ns = BOOT_SET;
      end

      // load the boot address into the fetch stage
      BOOT_SET: begin
        pc_set_o    = 1'b1;
        pc_mux_o    = PC_BOOT;
        ctrl_fsm_ns = FIRST_FETCH;
      end

      // one cycle of drain before sleeping
      WAIT_SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        ctrl_fsm_ns = SLEEP;
      end

      // wake on enable or on an enabled interrupt
      SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_enable_i || trap.irq_take)
          ctrl_fsm_ns = FIRST_FETCH;
      end

      // wait for the first instruction to reach ID
      FIRST_FETCH: begin
        first_fetch_o = 1'b1;
        if (id_ready_i)
          ctrl_fsm_ns = DECODE;
      end

      DECODE: begin
        if (instr_valid_i) begin
          is_decoding_o = 1'b1;
          if (branch_set_i || jump_set_i) begin
            // taken branch or jump redirects right away
            pc_set_o = 1'b1;
            pc_mux_o = PC_JUMP;
          end else if (trap.flush_req) begin
            halt_if_o   = 1'b1;
            halt_id_o   = 1'b1;
            ctrl_fsm_ns = FLUSH;
          end else if (irq_allowed) begin
            halt_if_o   = 1'b1;
            halt_id_o   = 1'b1;
            ctrl_fsm_ns = IRQ_TAKEN;
          end
        end else if (trap.irq_take) begin
          // bubble in ID, nothing to protect
          halt_if_o   = 1'b1;
          halt_id_o   = 1'b1;
          ctrl_fsm_ns = IRQ_TAKEN;
        end
      end

      // pipeline empty, act on the held trap
      FLUSH: begin
        halt_if_o    = ~fetch_enable_i;
        halt_id_o    = 1'b1;
        pc_mux_o     = trap.pc_sel;
        exc_pc_mux_o = trap.exc_pc_sel;
        exc_cause_o  = trap.exc_cause;
        csr_cause_o  = trap.csr_cause;
        case (trap.kind)
          TRAP_ECALL, TRAP_ILLEGAL: begin
            pc_set_o         = 1'b1;
            csr_save_id_o    = 1'b1;
            csr_save_cause_o = 1'b1;
          end
          TRAP_MRET: begin
            pc_set_o           = 1'b1;
            csr_restore_mret_o = 1'b1;
          end
          default: begin
            // ebreak and quiet flushes only drain the pipe
            pc_set_o = 1'b0;
          end
        endcase
        if (fetch_enable_i)
          ctrl_fsm_ns = DECODE;
        else
          ctrl_fsm_ns = WAIT_SLEEP;
      end

      // jump to the interrupt vector and save the if-stage pc
      IRQ_TAKEN: begin
        pc_set_o         = 1'b1;
        pc_mux_o         = PC_EXCEPTION;
        exc_pc_mux_o     = EXC_PC_IRQ;
        exc_cause_o      = trap.exc_cause;
        csr_cause_o      = trap.csr_cause;
        csr_save_if_o    = 1'b1;
        csr_save_cause_o = 1'b1;
        irq_ack_o        = 1'b1;
        exc_ack_o        = 1'b1;
        ctrl_fsm_ns      = DECODE;
      end

      default: begin
        instr_req_o = 1'b0;
        ctrl_fsm_ns = RESET;
      end
    endcase
  end

  // state register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      ctrl_fsm_cs <= RESET;
    else
      ctrl_fsm_cs <= ctrl_fsm_ns;
  end

endmodule

// File: core_controller.sv
////////////////////////////////////////////////////////////////////////////
// core controller top
// trap classifier feeding the main control FSM through the trap record
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module core_controller (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                fetch_enable_i,
  input  logic                                instr_valid_i,
  input  logic                                id_ready_i,
  input  logic                                branch_set_i,
  input  logic                                jump_set_i,
  input  logic                                branch_in_id_i,
  input  logic                                instr_multicycle_i,
  input  logic                                illegal_insn_i,
  input  logic                                ecall_insn_i,
  input  logic                                mret_insn_i,
  input  logic                                ebrk_insn_i,
  input  logic                                csr_status_i,
  input  logic                                pipe_flush_i,
  input  logic                                irq_req_i,
  input  logic                                m_ie_i,
  input  logic [trap_cause_pkg::IRQ_ID_W-1:0] irq_id_i,
  output logic [trap_cause_pkg::IRQ_ID_W-1:0] irq_id_o,
  output logic                                ctrl_busy_o,
  output logic                                first_fetch_o,
  output logic                                is_decoding_o,
  output logic                                instr_req_o,
  output logic                                pc_set_o,
  output ctrl_state_pkg::pc_sel_e             pc_mux_o,
  output ctrl_state_pkg::exc_pc_sel_e         exc_pc_mux_o,
  output logic [trap_cause_pkg::CAUSE_W-1:0]  exc_cause_o,
  output logic [trap_cause_pkg::CAUSE_W-1:0]  csr_cause_o,
  output logic                                irq_ack_o,
  output logic                                exc_ack_o,
  output logic                                csr_save_if_o,
  output logic                                csr_save_id_o,
  output logic                                csr_save_cause_o,
  output logic                                csr_restore_mret_o,
  output logic                                halt_if_o,
  output logic                                halt_id_o
);

  // classified trap record, combinational from the decoder flags
  trap_if trap_if_inst ();

  trap_classify trap_classify_inst (
    .illegal_insn_i (illegal_insn_i),
    .ecall_insn_i   (ecall_insn_i),
    .mret_insn_i    (mret_insn_i),
    .ebrk_insn_i    (ebrk_insn_i),
    .csr_status_i   (csr_status_i),
    .pipe_flush_i   (pipe_flush_i),
    .irq_req_i      (irq_req_i),
    .m_ie_i         (m_ie_i),
    .irq_id_i       (irq_id_i),
    .trap           (trap_if_inst.classify)
  );

  ctrl_fsm ctrl_fsm_inst (
    .clk                (clk),
    .rst_n              (rst_n),
    .fetch_enable_i     (fetch_enable_i),
    .instr_valid_i      (instr_valid_i),
    .id_ready_i         (id_ready_i),
    .branch_set_i       (branch_set_i),
    .jump_set_i         (jump_set_i),
    .branch_in_id_i     (branch_in_id_i),
    .instr_multicycle_i (instr_multicycle_i),
    .trap               (trap_if_inst.fsm),
    .ctrl_busy_o        (ctrl_busy_o),
    .first_fetch_o      (first_fetch_o),
    .is_decoding_o      (is_decoding_o),
    .instr_req_o        (instr_req_o),
    .pc_set_o           (pc_set_o),
    .pc_mux_o           (pc_mux_o),
    .exc_pc_mux_o       (exc_pc_mux_o),
    .exc_cause_o        (exc_cause_o),
    .csr_cause_o        (csr_cause_o),
    .irq_ack_o          (irq_ack_o),
    .exc_ack_o          (exc_ack_o),
    .csr_save_if_o      (csr_save_if_o),
    .csr_save_id_o      (csr_save_id_o),
    .csr_save_cause_o   (csr_save_cause_o),
    .csr_restore_mret_o (csr_restore_mret_o),
    .halt_if_o          (halt_if_o),
    .halt_id_o          (halt_id_o)
  );

  // id of the interrupt being acknowledged, back to the interrupt controller
  assign irq_id_o = irq_id_i;

endmodule

// File: core_controller_sva.sv
////////////////////////////////////////////////////////////////////////////
// controller assertions
// pc set, interrupt ack and csr save rules, bound to the controller top
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module core_controller_sva (
  input logic                        clk,
  input logic                        rst_n,
  input ctrl_state_pkg::ctrl_state_e state_i,
  input logic                        pc_set_i,
  input ctrl_state_pkg::pc_sel_e     pc_mux_i,
  input logic                        irq_ack_i,
  input logic                        csr_save_id_i
);
  import ctrl_state_pkg::*;

  // no redirect while idle after reset or asleep
  pc_set_idle_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state_i == RESET || state_i == SLEEP) |-> !pc_set_i
  ) else $error("pc_set_o high in RESET or SLEEP");

  // interrupt ack is a single-cycle strobe
  irq_ack_pulse_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    irq_ack_i |=> !irq_ack_i
  ) else $error("irq_ack_o held longer than one cycle");

  // id-stage pc saved only on an exception redirect
  save_id_exc_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    csr_save_id_i |-> (pc_mux_i == PC_EXCEPTION)
  ) else $error("csr_save_id_o without PC_EXCEPTION on pc_mux_o");

endmodule

bind core_controller core_controller_sva core_controller_sva_inst (
  .clk           (clk),
  .rst_n         (rst_n),
  .state_i       (ctrl_fsm_inst.ctrl_fsm_cs),
  .pc_set_i      (pc_set_o),
  .pc_mux_i      (pc_mux_o),
  .irq_ack_i     (irq_ack_o),
  .csr_save_id_i (csr_save_id_o)
);

// File: tb_core_controller.sv
////////////////////////////////////////////////////////////////////////////
// core controller testbench
// boot sequence, then a table of jump, flush, interrupt and sleep
// scenarios applied to the controller top and checked per row
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_core_controller;
  import ctrl_state_pkg::*;
  import trap_cause_pkg::*;

  // scenario kinds
  localparam logic [1:0] SC_JUMP  = 2'd0;
  localparam logic [1:0] SC_FLUSH = 2'd1;
  localparam logic [1:0] SC_IRQ   = 2'd2;

  // decoder flags {ecall, illegal, mret, ebreak, csr status, pipe flush}
  localparam logic [5:0] F_ECALL = 6'h20;
  localparam logic [5:0] F_ILL   = 6'h10;
  localparam logic [5:0] F_MRET  = 6'h08;
  localparam logic [5:0] F_EBRK  = 6'h04;
  localparam logic [5:0] F_CSR   = 6'h02;
  localparam logic [5:0] F_PFL   = 6'h01;

  // strobes {pc_set, save_id, save_cause, restore_mret, irq_ack, exc_ack, save_if}
  localparam logic [6:0] S_PC_SET = 7'h40;
  localparam logic [6:0] S_MRET   = 7'h08;
  localparam logic [6:0] ST_TRAP  = 7'h70;
  localparam logic [6:0] ST_IRQ   = 7'h57;

  // exception view cause words
  localparam logic [CAUSE_W-1:0] C_ECALL = {1'b0, EXC_ECALL_M};
  localparam logic [CAUSE_W-1:0] C_ILL   = {1'b0, EXC_ILLEGAL};
  localparam logic [CAUSE_W-1:0] C_BRK   = {1'b0, EXC_BREAKPOINT};

  typedef struct packed {
    logic [1:0]          sc;
    logic [5:0]          flags;
    logic [1:0]          br_jmp;
    logic                irq_req;
    logic                m_ie;
    logic                multicycle;
    logic                fetch_en;
    logic [IRQ_ID_W-1:0] irq_id;
    logic [2:0]          exp_pc_mux;
    logic [1:0]          exp_exc_pc_mux;
    logic [CAUSE_W-1:0]  exp_exc_cause;
    logic [CAUSE_W-1:0]  exp_csr_cause;
    logic [6:0]          exp_strobes;
  } row_t;

  logic                clk;
  logic                rst_n;
  logic                fetch_enable_i;
  logic                instr_valid_i;
  logic                id_ready_i;
  logic                branch_set_i;
  logic                jump_set_i;
  logic                branch_in_id_i;
  logic                instr_multicycle_i;
  logic                illegal_insn_i;
  logic                ecall_insn_i;
  logic                mret_insn_i;
  logic                ebrk_insn_i;
  logic                csr_status_i;
  logic                pipe_flush_i;
  logic                irq_req_i;
  logic                m_ie_i;
  logic [IRQ_ID_W-1:0] irq_id_i;
  logic [IRQ_ID_W-1:0] irq_id_o;
  logic                ctrl_busy_o;
  logic                first_fetch_o;
  logic                is_decoding_o;
  logic                instr_req_o;
  logic                pc_set_o;
  pc_sel_e             pc_mux_o;
  exc_pc_sel_e         exc_pc_mux_o;
  logic [CAUSE_W-1:0]  exc_cause_o;
  logic [CAUSE_W-1:0]  csr_cause_o;
  logic                irq_ack_o;
  logic                exc_ack_o;
  logic                csr_save_if_o;
  logic                csr_save_id_o;
  logic                csr_save_cause_o;
  logic                csr_restore_mret_o;
  logic                halt_if_o;
  logic                halt_id_o;

  row_t        rows[$];
  logic [31:0] lfsr_state;
  int          checks = 0;
  int          errors = 0;
  int          cycles = 0;
  bit          table_built = 1'b0;

  core_controller core_controller_inst (.*);

  // 10 ns clock
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////////

  // one step of a 32-bit Galois LFSR
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'hA300_0000;
    return s >> 1;
  endfunction

  // one LFSR step per id bit
  task automatic random_id(output logic [IRQ_ID_W-1:0] id);
    for (int i = 0; i < IRQ_ID_W; i++) begin
      id[i]      = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  // inputs change 1 ns after the rising edge, outputs read at the falling edge
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic sample();
    @(negedge clk);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s is %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // valid instruction in decode, nothing pending
  task automatic drive_idle(input logic fen);
    fetch_enable_i     = fen;
    instr_valid_i      = 1'b1;
    id_ready_i         = 1'b1;
    branch_set_i       = 1'b0;
    jump_set_i         = 1'b0;
    branch_in_id_i     = 1'b0;
    instr_multicycle_i = 1'b0;
    irq_req_i          = 1'b0;
    m_ie_i             = 1'b1;
    {ecall_insn_i, illegal_insn_i, mret_insn_i, ebrk_insn_i,
     csr_status_i, pipe_flush_i} = 6'h00;
  endtask

  task automatic drive_row(input row_t r);
    fetch_enable_i             = r.fetch_en;
    {branch_set_i, jump_set_i} = r.br_jmp;
    irq_req_i                  = r.irq_req;
    m_ie_i                     = r.m_ie;
    instr_multicycle_i         = r.multicycle;
    irq_id_i                   = r.irq_id;
    {ecall_insn_i, illegal_insn_i, mret_insn_i, ebrk_insn_i,
     csr_status_i, pipe_flush_i} = r.flags;
  endtask

  task automatic check_row(input row_t r);
    check_value("pc_set_o", 32'(pc_set_o), 32'(r.exp_strobes[6]));
    check_value("pc_mux_o", 32'(pc_mux_o), 32'(r.exp_pc_mux));
    check_value("exc_pc_mux_o", 32'(exc_pc_mux_o), 32'(r.exp_exc_pc_mux));
    check_value("exc_cause_o", 32'(exc_cause_o), 32'(r.exp_exc_cause));
    check_value("csr_cause_o", 32'(csr_cause_o), 32'(r.exp_csr_cause));
    check_value("csr_save_id_o", 32'(csr_save_id_o), 32'(r.exp_strobes[5]));
    check_value("csr_save_cause_o", 32'(csr_save_cause_o), 32'(r.exp_strobes[4]));
    check_value("csr_restore_mret_o", 32'(csr_restore_mret_o), 32'(r.exp_strobes[3]));
    check_value("irq_ack_o", 32'(irq_ack_o), 32'(r.exp_strobes[2]));
    check_value("exc_ack_o", 32'(exc_ack_o), 32'(r.exp_strobes[1]));
    check_value("csr_save_if_o", 32'(csr_save_if_o), 32'(r.exp_strobes[0]));
    if (r.exp_strobes[2])
      check_value("irq_id_o", 32'(irq_id_o), 32'(r.irq_id));
  endtask

  // bounded wait for the first fetch state
  task automatic wait_first_fetch(input int max_cycles);
    int n;
    n = 0;
    sample();
    while (!first_fetch_o && n < max_cycles) begin
      step();
      sample();
      n++;
    end
    if (!first_fetch_o) begin
      errors++;
      $display("controller did not reach first fetch within %0d cycles", max_cycles);
    end
  endtask

  // entered in the wait-sleep cycle, leaves in decode
  task automatic sleep_and_wake();
    sample();
    check_value("instr_req_o", 32'(instr_req_o), 32'd0);
    for (int i = 0; i < 3; i++) begin
      step();
      sample();
      check_value("instr_req_o", 32'(instr_req_o), 32'd0);
      check_value("pc_set_o", 32'(pc_set_o), 32'd0);
    end
    // enabled interrupt wakes the core
    step();
    irq_req_i = 1'b1;
    wait_first_fetch(4);
    step();
    drive_idle(1'b1);
  endtask

  task automatic run_row(input row_t r);
    drive_row(r);
    if (r.sc == SC_JUMP) begin
      sample();
      check_value("is_decoding_o", 32'(is_decoding_o), 32'd1);
      check_row(r);
      step();
      drive_idle(1'b1);
    end else begin
      if (r.sc == SC_FLUSH) begin
        sample();
        check_value("is_decoding_o", 32'(is_decoding_o), 32'd1);
        check_value("halt_if_o", 32'(halt_if_o), 32'd1);
        check_value("halt_id_o", 32'(halt_id_o), 32'd1);
      end
      step();
      // flush keeps the decoder flags held, an interrupt drops its request
      if (r.sc == SC_IRQ)
        drive_idle(1'b1);
      sample();
      check_row(r);
      step();
      drive_idle(r.fetch_en);
      if (!r.fetch_en)
        sleep_and_wake();
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////////////////////////////

  // columns: kind, flags, {branch, jump}, irq, m_ie, multicycle, fetch enable,
  // irq id, then expected pc_mux, exc_pc_mux, exc_cause, csr_cause, strobes
  task automatic build_table();
    logic [IRQ_ID_W-1:0] id;
    rows.push_back(row_t'{SC_JUMP, 6'h00, 2'b10, 1'b0, 1'b1, 1'b0, 1'b1, 5'd0,
                          PC_JUMP, EXC_PC_IRQ, 6'h00, 6'h00, S_PC_SET});
    rows.push_back(row_t'{SC_JUMP, 6'h00, 2'b01, 1'b0, 1'b1, 1'b0, 1'b1, 5'd0,
                          PC_JUMP, EXC_PC_IRQ, 6'h00, 6'h00, S_PC_SET});
    // single flush kinds
    rows.push_back(row_t'{SC_FLUSH, F_ECALL, 2'b00, 1'b0, 1'b1, 1'b0, 1'b1, 5'd0,
                          PC_EXCEPTION, EXC_PC_ECALL, C_ECALL, C_ECALL, ST_TRAP});
    rows.push_back(row_t'{SC_FLUSH, F_ILL, 2'b00, 1'b0, 1'b1, 1'b0, 1'b1, 5'd0,
                          PC_EXCEPTION, EXC_PC_ILLINSN, C_ILL, C_ILL, ST_TRAP});
    rows.push_back(row_t'{SC_FLUSH, F_MRET, 2'b00, 1'b0, 1'b1, 1'b0, 1'b1, 5'd0,
                          PC_ERET, EXC_PC_IRQ, 6'h00, 6'h00, S_PC_SET | S_MRET});
    rows.push_back(row_t'{SC_FLUSH, F_EBRK, 2'b00, 1'b0, 1'b1, 1'b0, 1'b1, 5'd0,
                          PC_BOOT, EXC_PC_IRQ, C_BRK, 6'h00, 7'h00});
    rows.push_back(row_t'{SC_FLUSH, F_CSR, 2'b00, 1'b0, 1'b1, 1'b0, 1'b1, 5'd0,
                          PC_BOOT, EXC_PC_IRQ, 6'h00, 6'h00, 7'h00});
    rows.push_back(row_t'{SC_FLUSH, F_PFL, 2'b00, 1'b0, 1'b1, 1'b0, 1'b1, 5'd0,
                          PC_BOOT, EXC_PC_IRQ, 6'h00, 6'h00, 7'h00});
    // simultaneous flags, highest priority wins
    rows.push_back(row_t'{SC_FLUSH, F_ECALL | F_ILL | F_MRET, 2'b00, 1'b0, 1'b1, 1'b0,
                          1'b1, 5'd0, PC_EXCEPTION, EXC_PC_ECALL, C_ECALL, C_ECALL, ST_TRAP});
    rows.push_back(row_t'{SC_FLUSH, F_ILL | F_MRET | F_EBRK, 2'b00, 1'b0, 1'b1, 1'b0,
                          1'b1, 5'd0, PC_EXCEPTION, EXC_PC_ILLINSN, C_ILL, C_ILL, ST_TRAP});
    rows.push_back(row_t'{SC_FLUSH, F_MRET | F_EBRK | F_CSR, 2'b00, 1'b0, 1'b1, 1'b0,
                          1'b1, 5'd0, PC_ERET, EXC_PC_IRQ, 6'h00, 6'h00, S_PC_SET | S_MRET});
    rows.push_back(row_t'{SC_FLUSH, F_EBRK | F_PFL, 2'b00, 1'b0, 1'b1, 1'b0, 1'b1, 5'd0,
                          PC_BOOT, EXC_PC_IRQ, C_BRK, 6'h00, 7'h00});
    // enabled interrupts with random ids
    for (int i = 0; i < 2; i++) begin
      random_id(id);
      rows.push_back(row_t'{SC_IRQ, 6'h00, 2'b00, 1'b1, 1'b1, 1'b0, 1'b1, id,
                            PC_EXCEPTION, EXC_PC_IRQ, {1'b0, id}, {1'b1, id}, ST_IRQ});
    end
    // disabled, then blocked by a multicycle op
    random_id(id);
    rows.push_back(row_t'{SC_IRQ, 6'h00, 2'b00, 1'b1, 1'b0, 1'b0, 1'b1, id,
                          PC_BOOT, EXC_PC_IRQ, 6'h00, 6'h00, 7'h00});
    random_id(id);
    rows.push_back(row_t'{SC_IRQ, 6'h00, 2'b00, 1'b1, 1'b1, 1'b1, 1'b1, id,
                          PC_BOOT, EXC_PC_IRQ, 6'h00, 6'h00, 7'h00});
    // fetch enable low, flush then sleep and wake
    rows.push_back(row_t'{SC_FLUSH, F_PFL, 2'b00, 1'b0, 1'b1, 1'b0, 1'b0, 5'd0,
                          PC_BOOT, EXC_PC_IRQ, 6'h00, 6'h00, 7'h00});
    rows.push_back(row_t'{SC_FLUSH, F_ECALL, 2'b00, 1'b0, 1'b1, 1'b0, 1'b0, 5'd0,
                          PC_EXCEPTION, EXC_PC_ECALL, C_ECALL, C_ECALL, ST_TRAP});
  endtask

  //////////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////////

  initial begin
    rst_n      = 1'b0;
    irq_id_i   = '0;
    lfsr_state = 32'h6692_a2d0;
    drive_idle(1'b0);
    build_table();
    table_built = 1'b1;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // idle in reset until enabled
    sample();
    check_value("ctrl_busy_o", 32'(ctrl_busy_o), 32'd0);
    check_value("instr_req_o", 32'(instr_req_o), 32'd0);
    check_value("pc_set_o", 32'(pc_set_o), 32'd0);
    step();
    fetch_enable_i = 1'b1;
    step();
    sample();
    check_value("pc_set_o", 32'(pc_set_o), 32'd1);
    check_value("pc_mux_o", 32'(pc_mux_o), 32'(PC_BOOT));
    step();
    sample();
    check_value("pc_set_o", 32'(pc_set_o), 32'd0);
    check_value("first_fetch_o", 32'(first_fetch_o), 32'd1);
    foreach (rows[i]) begin
      step();
      run_row(rows[i]);
    end
    step();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

  // run limit from the table length
  initial begin
    int limit;
    wait (table_built);
    limit = 40 * rows.size() + 100;
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run passed the limit of %0d cycles", limit);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: core_controller.f
ctrl_state_pkg.sv
trap_cause_pkg.sv
trap_if.sv
trap_classify.sv
ctrl_fsm.sv
core_controller.sv
core_controller_sva.sv
tb_core_controller.sv

// File: run.sh
#!/bin/sh
# compile and run the core controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f core_controller.f \
  --top-module tb_core_controller -o sim_core_controller

status=0
output=$(./obj_dir/sim_core_controller 2>&1) || status=$?
echo "$output"
[ "$status" -eq 0 ] || exit "$status"

if echo "$output" | grep -qx "RESULT: PASS"; then
  exit 0
fi
exit 1
